// File: Makefile
# Verilator build and run for the frame-buffer scan-out testbench

VERILATOR   ?= verilator
TOP         ?= fb_display_tb
FLIST       ?= fb_display.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_MSG    ?= Simulation completed successfully
VFLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing -Wall
EXTRA_FLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: fb_display.f
verilog/lcd_pkg.sv
verilog/mig_pkg.sv
verilog/lcd_scan_gen.sv
verilog/fb_line_prefetch.sv
verilog/fb_display.sv
sim/fb_display_checker.sv
sim/fb_display_tb.sv

// File: sim/fb_display_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fb_display_checker #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 6,
    parameter int H_BLANK  = 4,
    parameter int V_BLANK  = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  mig_pkg::mig_cmd_t    mig_cmd_i,
    input  mig_pkg::mig_rd_req_t mig_rd_req_i,
    input  mig_pkg::mig_rd_rsp_t mig_rd_rsp_i,
    input  lcd_pkg::lcd_out_t    out_i,
    input  logic                 ack_i,
    input  logic                 underrun_i,
    input  logic [5:0]           key_i,
    input  logic                 exp_underrun_i,
    input  int                   test_num_i,
    input  logic                 test_end_i,
    input  logic                 run_done_i,
    output int                   ack_count_o,
    output int                   error_count_o
);

    import lcd_pkg::*;
    import mig_pkg::*;

    localparam int SLOTS_PER_FRAME = (H_ACTIVE + H_BLANK) * (V_ACTIVE + V_BLANK);

    int   acks;
    int   active_acks;
    int   test_errors;
    int   total_errors;
    int   tests_run;
    int   tests_failed;
    int   ex;
    int   ey;
    int   cx;
    int   cy;
    logic seen_ack;
    logic ack_prev;
    logic prev_hsync;
    logic prev_vsync;
    logic underrun_seen;
    logic underrun_reported;

    assign ack_count_o   = acks;
    assign error_count_o = total_errors + test_errors;

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp_val, got_val);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t: %s", $time, what);
        test_errors++;
    endtask

    task automatic check_ack();
        lcd_pixel_t exp_pix;
        if (ack_prev) begin
            report_problem("ack_o was high in two consecutive cycles");
        end
        // every frame opens with the first vertical blanking slot
        if (acks % SLOTS_PER_FRAME == 0) begin
            if (out_i.vsync !== 1'b1 || out_i.x !== '0 || out_i.y !== '0) begin
                report_problem("frame does not start with a vertical blanking slot");
            end
            if (acks > 0 && !(prev_hsync && !prev_vsync)) begin
                report_problem("ack count per frame differs from the request slot count");
            end
        end
        if (out_i.hsync === 1'b0 && out_i.vsync === 1'b0) begin
            if (out_i.x !== 9'(ex)) begin
                report_mismatch("out_o.x", 32'(ex), 32'(out_i.x));
            end
            if (out_i.y !== 7'(ey)) begin
                report_mismatch("out_o.y", 32'(ey), 32'(out_i.y));
            end
            if (!exp_underrun_i) begin
                exp_pix.r = 6'((ey + int'(key_i)) % 64);
                exp_pix.g = 6'(ex % 64);
                exp_pix.b = 6'((ex / 8 + int'(key_i)) % 64);
                if (out_i.pixel !== exp_pix) begin
                    report_mismatch("out_o.pixel", 32'(exp_pix), 32'(out_i.pixel));
                end
            end
            active_acks++;
            ex++;
            if (ex == H_ACTIVE) begin
                ex = 0;
                ey = (ey == V_ACTIVE - 1) ? 0 : ey + 1;
            end
        end
        prev_hsync = out_i.hsync;
        prev_vsync = out_i.vsync;
        seen_ack   = 1'b1;
        acks++;
    endtask

    task automatic check_command();
        logic [29:0] exp_addr;
        int          cmd_x;
        cmd_x = int'(mig_cmd_i.byte_addr[10:2]);
        if (mig_cmd_i.instr !== MIG_INSTR_READ) begin
            report_mismatch("mig_cmd_o.instr", 32'(MIG_INSTR_READ), 32'(mig_cmd_i.instr));
        end
        if (mig_cmd_i.bl !== 6'd7) begin
            report_mismatch("mig_cmd_o.bl", 32'd7, 32'(mig_cmd_i.bl));
        end
        if (mig_cmd_i.byte_addr[29:18] !== '0 || mig_cmd_i.byte_addr[1:0] !== '0) begin
            report_problem("command address has bits set outside the pixel fields");
        end
        if (cmd_x % 8 != 0) begin
            report_problem("command x is not a multiple of 8");
        end
        if (out_i.vsync === 1'b1) begin
            report_problem("command issued during vertical blanking");
        end
        if (mig_rd_rsp_i.cmd_full) begin
            report_problem("command issued while the command FIFO was full");
        end
        // block order only holds when every fetch finishes in time
        if (!exp_underrun_i) begin
            exp_addr = 30'((cy << 11) | (cx << 2));
            if (mig_cmd_i.byte_addr !== exp_addr) begin
                report_mismatch("mig_cmd_o.byte_addr", 32'(exp_addr), 32'(mig_cmd_i.byte_addr));
            end
            cx += 8;
            if (cx == H_ACTIVE) begin
                cx = 0;
                cy = (cy == V_ACTIVE - 1) ? 0 : cy + 1;
            end
        end
    endtask

    task automatic finish_test();
        if (underrun_i !== exp_underrun_i) begin
            report_mismatch("underrun_o", 32'(exp_underrun_i), 32'(underrun_i));
        end
        if (active_acks != 2 * H_ACTIVE * V_ACTIVE) begin
            report_problem("wrong number of active pixels over two frames");
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok, %0d acks", test_num_i, acks);
        end else begin
            tests_failed++;
            $display("test %0d: %0d errors", test_num_i, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // outputs move on the rising edge, sample in the middle of the cycle
    always @(negedge clk) begin
        if (rst) begin
            acks              = 0;
            active_acks       = 0;
            test_errors       = 0;
            ex                = 0;
            ey                = 0;
            cx                = 0;
            cy                = 0;
            seen_ack          = 1'b0;
            ack_prev          = 1'b0;
            prev_hsync        = 1'b0;
            prev_vsync        = 1'b0;
            underrun_seen     = 1'b0;
            underrun_reported = 1'b0;
        end else begin
            if (!seen_ack && ack_i !== 1'b1) begin
                if (mig_cmd_i.en !== 1'b0 || mig_rd_req_i.en !== 1'b0 || underrun_i !== 1'b0) begin
                    report_problem("outputs active before the first pixel request");
                end
            end
            if (ack_i === 1'b1) begin
                check_ack();
            end
            if (mig_cmd_i.en === 1'b1) begin
                check_command();
            end
            if (!exp_underrun_i && underrun_i !== 1'b0 && !underrun_reported) begin
                report_problem("underrun_o went high with a short read latency");
                underrun_reported = 1'b1;
            end
            if (underrun_seen && underrun_i !== 1'b1) begin
                report_problem("underrun_o dropped before reset");
            end
            underrun_seen = (underrun_i === 1'b1);
            ack_prev = (ack_i === 1'b1);
            if (test_end_i) begin
                finish_test();
            end
        end
        if (run_done_i) begin
            $display("tests run %0d, tests failed %0d, errors %0d",
                     tests_run, tests_failed, total_errors);
        end
    end

    initial begin
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        acks         = 0;
    end

endmodule

`default_nettype wire

// File: sim/fb_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fb_display_tb;

    import lcd_pkg::*;
    import mig_pkg::*;

    localparam int H_ACTIVE        = 64;
    localparam int V_ACTIVE        = 6;
    localparam int H_BLANK         = 4;
    localparam int V_BLANK         = 2;
    localparam int PIX_DIV         = 6;
    localparam int CLK_HALF        = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int SLOTS_PER_FRAME = (H_ACTIVE + H_BLANK) * (V_ACTIVE + V_BLANK);
    localparam int FRAME_CYCLES    = SLOTS_PER_FRAME * PIX_DIV;
    localparam int MAX_TESTS       = 16;
    localparam int VEC_FIELDS      = 4;
    localparam int BURST_WORDS     = 8;
    // empty cycles allowed inside one burst
    localparam int GAP_CAP         = 4;

    logic        clk;
    logic        rst;
    mig_cmd_t    mig_cmd;
    mig_rd_req_t mig_rd_req;
    mig_rd_rsp_t mig_rd_rsp = '{data: '0, empty: 1'b1, cmd_full: 1'b0};
    lcd_out_t    lcd_out;
    logic        ack;
    logic        underrun;

    logic [15:0] vec_mem [MAX_TESTS * VEC_FIELDS];
    int          num_tests;
    logic [15:0] cur_latency;
    logic [15:0] cur_stall;
    logic [5:0]  cur_key;
    logic        cur_exp_underrun;
    int          cur_test;
    logic        test_end;
    logic        run_done;
    int          ack_count;
    int          error_count;

    int unsigned cycle_cnt;
    int unsigned stall_left;
    int          word_idx;
    int          gaps_left;
    int unsigned ready_q [$];
    logic [29:0] addr_q [$];

    fb_display #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .H_BLANK  (H_BLANK),
        .V_BLANK  (V_BLANK),
        .PIX_DIV  (PIX_DIV)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .mig_cmd_o    (mig_cmd),
        .mig_rd_req_o (mig_rd_req),
        .mig_rd_rsp_i (mig_rd_rsp),
        .out_o        (lcd_out),
        .ack_o        (ack),
        .underrun_o   (underrun)
    );

    fb_display_checker #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .H_BLANK  (H_BLANK),
        .V_BLANK  (V_BLANK)
    ) u_checker (
        .clk            (clk),
        .rst            (rst),
        .mig_cmd_i      (mig_cmd),
        .mig_rd_req_i   (mig_rd_req),
        .mig_rd_rsp_i   (mig_rd_rsp),
        .out_i          (lcd_out),
        .ack_i          (ack),
        .underrun_i     (underrun),
        .key_i          (cur_key),
        .exp_underrun_i (cur_exp_underrun),
        .test_num_i     (cur_test),
        .test_end_i     (test_end),
        .run_done_i     (run_done),
        .ack_count_o    (ack_count),
        .error_count_o  (error_count)
    );

    // word contents follow from the address: y in [17:11], x in [10:2]
    function automatic logic [31:0] pattern_word(input logic [29:0] base, input int idx,
                                                 input logic [5:0] key);
        int         xi;
        int         yi;
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
        yi = int'(base[17:11]);
        xi = int'(base[10:2]) + idx;
        r  = 6'((yi + int'(key)) % 64);
        g  = 6'(xi % 64);
        b  = 6'((xi / 8 + int'(key)) % 64);
        return {8'd0, r, 2'd0, g, 2'd0, b, 2'd0};
    endfunction

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // DDR3 controller model: command queue, latency, read FIFO with gaps
    always @(posedge clk) begin
        if (rst) begin
            ready_q.delete();
            addr_q.delete();
            cycle_cnt  = 0;
            word_idx   = 0;
            gaps_left  = GAP_CAP;
            stall_left = 32'(cur_stall);
            mig_rd_rsp.data     <= '0;
            mig_rd_rsp.empty    <= 1'b1;
            mig_rd_rsp.cmd_full <= (cur_stall != 16'd0);
        end else begin
            cycle_cnt = cycle_cnt + 1;
            if (stall_left > 0) begin
                stall_left = stall_left - 1;
            end
            mig_rd_rsp.cmd_full <= (stall_left != 0);
            if (mig_cmd.en) begin
                ready_q.push_back(cycle_cnt + 32'(cur_latency));
                addr_q.push_back(mig_cmd.byte_addr);
            end
            if (mig_rd_req.en && !mig_rd_rsp.empty) begin
                word_idx++;
                if (word_idx == BURST_WORDS) begin
                    void'(ready_q.pop_front());
                    void'(addr_q.pop_front());
                    word_idx  = 0;
                    gaps_left = GAP_CAP;
                end
            end
            if (ready_q.size() > 0 && cycle_cnt >= ready_q[0]) begin
                if (gaps_left > 0 && ($urandom % 4) == 0) begin
                    gaps_left--;
                    mig_rd_rsp.empty <= 1'b1;
                end else begin
                    mig_rd_rsp.empty <= 1'b0;
                    mig_rd_rsp.data  <= pattern_word(addr_q[0], word_idx, cur_key);
                end
            end else begin
                mig_rd_rsp.empty <= 1'b1;
            end
        end
    end

    initial begin
        int unsigned seed_val;
        logic        setup_error;
        seed_val         = $urandom(32'h854f_0e72);
        rst              = 1'b1;
        test_end         = 1'b0;
        run_done         = 1'b0;
        cur_latency      = '0;
        cur_stall        = '0;
        cur_key          = '0;
        cur_exp_underrun = 1'b0;
        cur_test         = 0;
        setup_error      = 1'b0;
        for (int i = 0; i < MAX_TESTS * VEC_FIELDS; i++) begin
            vec_mem[i] = 16'hffff;
        end
        $readmemh("sim/fb_display_vectors.txt", vec_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && vec_mem[num_tests * VEC_FIELDS] != 16'hffff) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no test vectors were read from the data file");
            setup_error = 1'b1;
        end
        for (int t = 0; t < num_tests; t++) begin
            @(posedge clk);
            cur_latency      <= vec_mem[t * VEC_FIELDS];
            cur_key          <= vec_mem[t * VEC_FIELDS + 1][5:0];
            cur_stall        <= vec_mem[t * VEC_FIELDS + 2];
            cur_exp_underrun <= vec_mem[t * VEC_FIELDS + 3][0];
            cur_test         <= t;
            rst              <= 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            rst <= 1'b0;
            // two full frames of request slots
            while (ack_count < 2 * SLOTS_PER_FRAME) begin
                @(posedge clk);
            end
            repeat (2) @(posedge clk);
            test_end <= 1'b1;
            @(posedge clk);
            test_end <= 1'b0;
        end
        @(posedge clk);
        run_done <= 1'b1;
        @(posedge clk);
        run_done <= 1'b0;
        @(posedge clk);
        if (error_count == 0 && !setup_error) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int unsigned limit;
        @(posedge clk);
        limit = 32'(num_tests * 2 * FRAME_CYCLES + 1000);
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/fb_display_vectors.txt
// columns: read latency, pattern key, cmd_full stall cycles, expected underrun (hex)
// latencies above the eight-request fill budget must raise underrun
02 00 0000 0
04 05 0014 0
06 2a 0100 0
03 3f 0190 0
05 1c 0000 0
32 11 0000 1
50 07 0040 1

// File: verilog/fb_display.sv
`timescale 1ns/1ps
`default_nettype none

module fb_display #(
    parameter int H_ACTIVE = 320,
    parameter int V_ACTIVE = 120,
    parameter int H_BLANK  = 32,
    parameter int V_BLANK  = 4,
    parameter int PIX_DIV  = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    output mig_pkg::mig_cmd_t    mig_cmd_o,
    output mig_pkg::mig_rd_req_t mig_rd_req_o,
    input  mig_pkg::mig_rd_rsp_t mig_rd_rsp_i,
    output lcd_pkg::lcd_out_t    out_o,
    output logic                 ack_o,
    output logic                 underrun_o
);

    import lcd_pkg::*;

    lcd_scan_t scan;

    lcd_scan_gen #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .H_BLANK  (H_BLANK),
        .V_BLANK  (V_BLANK),
        .PIX_DIV  (PIX_DIV)
    ) u_scan_gen (
        .clk    (clk),
        .rst    (rst),
        .scan_o (scan)
    );

    fb_line_prefetch #(
        .H_ACTIVE (H_ACTIVE),
        .PIX_DIV  (PIX_DIV)
    ) u_prefetch (
        .clk          (clk),
        .rst          (rst),
        .scan_i       (scan),
        .mig_cmd_o    (mig_cmd_o),
        .mig_rd_req_o (mig_rd_req_o),
        .mig_rd_rsp_i (mig_rd_rsp_i),
        .out_o        (out_o),
        .ack_o        (ack_o),
        .underrun_o   (underrun_o)
    );

endmodule

`default_nettype wire

// File: verilog/fb_line_prefetch.sv
`timescale 1ns/1ps
`default_nettype none

module fb_line_prefetch #(
    parameter int H_ACTIVE = 320,
    parameter int PIX_DIV  = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    input  lcd_pkg::lcd_scan_t   scan_i,
    output mig_pkg::mig_cmd_t    mig_cmd_o,
    output mig_pkg::mig_rd_req_t mig_rd_req_o,
    input  mig_pkg::mig_rd_rsp_t mig_rd_rsp_i,
    output lcd_pkg::lcd_out_t    out_o,
    output logic                 ack_o,
    output logic                 underrun_o
);

    import lcd_pkg::*;
    import mig_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EMIT,
        ST_FILL
    } state_t;

    // two bursts, one per cache half
    localparam int CACHE_DEPTH = 2 * MIG_BURST_WORDS;
    // cycles between a block request and its first use
    localparam int FILL_BUDGET = MIG_BURST_WORDS * PIX_DIV;

    state_t            state_q;
    logic [X_BITS-1:0] pf_x_q;
    logic [Y_BITS-1:0] pf_y_q;
    logic              zero_done_q;
    lcd_pixel_t        cache_mem [CACHE_DEPTH];
    lcd_pixel_t        rd_word_pix;
    lcd_out_t          out_q;
    logic              ack_q;
    logic              underrun_q;

    logic              active_pop;
    logic              blk_pop;
    logic              blk_req;
    logic              start_zero;
    logic              start_next;
    logic              busy;
    logic              take;
    logic              late_read;
    logic [X_BITS-1:0] next_x;

    assign active_pop = scan_i.pop && !scan_i.hsync && !scan_i.vsync;
    assign blk_pop    = scan_i.pop && !scan_i.vsync && (scan_i.x[2:0] == 3'd0);
    assign blk_req    = blk_pop && !scan_i.hsync;
    assign next_x     = scan_i.x + X_BITS'(MIG_BURST_WORDS);

    // block 0 once per blanking period, then one block ahead of the scan
    assign start_zero = blk_pop && scan_i.hsync && !zero_done_q;
    assign start_next = blk_req && (next_x < X_BITS'(H_ACTIVE));

    assign busy = (state_q != ST_IDLE);
    assign take = mig_rd_req_o.en && !mig_rd_rsp_i.empty;

    // pf_x_q[3] names the half being filled
    assign late_read = active_pop && busy && (scan_i.x[3] == pf_x_q[3]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            pf_x_q      <= '0;
            pf_y_q      <= '0;
            zero_done_q <= 1'b0;
        end else begin
            if (active_pop) begin
                zero_done_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (start_zero) begin
                        pf_x_q      <= '0;
                        pf_y_q      <= scan_i.y;
                        zero_done_q <= 1'b1;
                        state_q     <= ST_EMIT;
                    end else if (start_next) begin
                        pf_x_q  <= next_x;
                        pf_y_q  <= scan_i.y;
                        state_q <= ST_EMIT;
                    end
                end
                ST_EMIT: begin
                    // hold the command while the controller FIFO is full
                    if (!mig_rd_rsp_i.cmd_full) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (take) begin
                        pf_x_q[2:0] <= pf_x_q[2:0] + 3'd1;
                        if (pf_x_q[2:0] == 3'(MIG_BURST_WORDS - 1)) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        mig_cmd_o.en        = (state_q == ST_EMIT) && !mig_rd_rsp_i.cmd_full;
        mig_cmd_o.instr     = MIG_INSTR_READ;
        mig_cmd_o.bl        = MIG_BL_CODE;
        mig_cmd_o.byte_addr = mig_fb_addr(pf_y_q, pf_x_q);
    end

    assign mig_rd_req_o.en = (state_q == ST_FILL);

    // unpack channels from the controller word
    assign rd_word_pix.r = mig_rd_rsp_i.data[MIG_R_LSB +: PIX_BITS];
    assign rd_word_pix.g = mig_rd_rsp_i.data[MIG_G_LSB +: PIX_BITS];
    assign rd_word_pix.b = mig_rd_rsp_i.data[MIG_B_LSB +: PIX_BITS];

    always_ff @(posedge clk) begin
        if (take) begin
            cache_mem[pf_x_q[3:0]] <= rd_word_pix;
        end
    end

    // registered pixel, one cycle after pop
    always_ff @(posedge clk) begin
        if (scan_i.pop) begin
            out_q.pixel <= cache_mem[scan_i.x[3:0]];
            out_q.x     <= scan_i.x;
            out_q.y     <= scan_i.y;
            out_q.hsync <= scan_i.hsync;
            out_q.vsync <= scan_i.vsync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q      <= 1'b0;
            underrun_q <= 1'b0;
        end else begin
            ack_q <= scan_i.pop;
            // sticky until reset
            if ((blk_req && busy) || late_read) begin
                underrun_q <= 1'b1;
            end
        end
    end

    assign out_o      = out_q;
    assign ack_o      = ack_q;
    assign underrun_o = underrun_q;

    a_cmd_pulse: assert property (@(posedge clk) disable iff (rst)
        mig_cmd_o.en |=> !mig_cmd_o.en);

    // words only show up for the burst being filled
    a_no_stray_word: assert property (@(posedge clk) disable iff (rst)
        !mig_rd_req_o.en |-> mig_rd_rsp_i.empty);

    // command cycle plus a gapless burst has to fit in eight requests
    a_fill_budget: assert property (@(posedge clk)
        FILL_BUDGET > MIG_BURST_WORDS + 1);

endmodule

`default_nettype wire

// File: verilog/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // 18-bit panel, 6 bits per channel
    localparam int PIX_BITS = 6;

    // scan position widths
    localparam int X_BITS = 9;
    localparam int Y_BITS = 7;

    typedef struct packed {
        logic [PIX_BITS-1:0] r;
        logic [PIX_BITS-1:0] g;
        logic [PIX_BITS-1:0] b;
    } lcd_pixel_t;

    // one request slot from the scan generator
    typedef struct packed {
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
        logic              hsync;
        logic              vsync;
        logic              pop;
    } lcd_scan_t;

    // pixel plus the position it was fetched for
    typedef struct packed {
        lcd_pixel_t        pixel;
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
        logic              hsync;
        logic              vsync;
    } lcd_out_t;

endpackage

`default_nettype wire

// File: verilog/lcd_scan_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_scan_gen #(
    parameter int H_ACTIVE = 320,
    parameter int V_ACTIVE = 120,
    parameter int H_BLANK  = 32,
    parameter int V_BLANK  = 4,
    parameter int PIX_DIV  = 6
) (
    input  logic               clk,
    input  logic               rst,
    output lcd_pkg::lcd_scan_t scan_o
);

    import lcd_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_BLANK;
    localparam int V_TOTAL = V_ACTIVE + V_BLANK;
    localparam int DIV_W   = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
    localparam int SLOT_W  = $clog2(H_TOTAL);
    localparam int LINE_W  = $clog2(V_TOTAL);

    logic [DIV_W-1:0]  div_cnt_q;
    logic [SLOT_W-1:0] slot_cnt_q;
    logic [LINE_W-1:0] line_cnt_q;
    logic              slot_tick;
    logic              row_active;
    logic              in_hblank;
    logic              vsync_d;
    logic              hsync_d;
    logic [LINE_W-1:0] row;
    lcd_scan_t         scan_d;
    lcd_scan_t         scan_q;

    assign slot_tick = (div_cnt_q == DIV_W'(PIX_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt_q <= '0;
        end else if (slot_tick) begin
            div_cnt_q <= '0;
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    // active slots first, then horizontal blanking
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt_q <= '0;
            line_cnt_q <= '0;
        end else if (slot_tick) begin
            if (slot_cnt_q == SLOT_W'(H_TOTAL - 1)) begin
                slot_cnt_q <= '0;
                if (line_cnt_q == LINE_W'(V_TOTAL - 1)) begin
                    line_cnt_q <= '0;
                end else begin
                    line_cnt_q <= line_cnt_q + 1'b1;
                end
            end else begin
                slot_cnt_q <= slot_cnt_q + 1'b1;
            end
        end
    end

    // vertical blanking lines come first in the frame
    assign row_active = (line_cnt_q >= LINE_W'(V_BLANK));
    assign in_hblank  = (slot_cnt_q >= SLOT_W'(H_ACTIVE));
    assign row        = line_cnt_q - LINE_W'(V_BLANK);

    // hblank of the last vblank line leads into line 0
    assign vsync_d = !row_active && !(in_hblank && line_cnt_q == LINE_W'(V_BLANK - 1));
    assign hsync_d = in_hblank && !vsync_d;

    always_comb begin
        scan_d       = '0;
        scan_d.pop   = slot_tick;
        scan_d.vsync = vsync_d;
        scan_d.hsync = hsync_d;
        if (hsync_d) begin
            // next line to show, wraps to 0 after the last one
            if (row_active && row != LINE_W'(V_ACTIVE - 1)) begin
                scan_d.y = Y_BITS'(row + 1'b1);
            end
        end else if (!vsync_d) begin
            scan_d.x = X_BITS'(slot_cnt_q);
            scan_d.y = Y_BITS'(row);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_q <= '0;
        end else begin
            scan_q <= scan_d;
        end
    end

    assign scan_o = scan_q;

    a_pop_strobe: assert property (@(posedge clk) disable iff (rst)
        scan_q.pop |=> !scan_q.pop);

endmodule

`default_nettype wire

// File: verilog/mig_pkg.sv
`default_nettype none

package mig_pkg;

    localparam logic [2:0] MIG_INSTR_READ = 3'b001;

    // words per burst, bl field carries length minus one
    localparam int         MIG_BURST_WORDS = 8;
    localparam logic [5:0] MIG_BL_CODE     = 6'(MIG_BURST_WORDS - 1);

    // frame buffer byte address: y in [17:11], x in [10:2]
    localparam int MIG_ADDR_X_LSB = 2;
    localparam int MIG_ADDR_Y_LSB = 11;

    // channel positions inside a 32-bit word
    localparam int MIG_R_LSB = 18;
    localparam int MIG_G_LSB = 10;
    localparam int MIG_B_LSB = 2;

    typedef struct packed {
        logic        en;
        logic [2:0]  instr;
        logic [5:0]  bl;
        logic [29:0] byte_addr;
    } mig_cmd_t;

    typedef struct packed {
        logic en;
    } mig_rd_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        empty;
        logic        cmd_full;
    } mig_rd_rsp_t;

    function automatic logic [29:0] mig_fb_addr(input logic [6:0] y, input logic [8:0] x);
        logic [29:0] addr;
        addr = '0;
        addr[MIG_ADDR_Y_LSB +: 7] = y;
        addr[MIG_ADDR_X_LSB +: 9] = x;
        return addr;
    endfunction

endpackage

`default_nettype wire
